// File: src/memExDefines.svh
// ##################################################
// Widths and constants shared by the RTL and the testbench
// The region code sits in the top four address bits
// ##################################################
`ifndef MEM_EX_DEFINES_SVH
`define MEM_EX_DEFINES_SVH

// Datapath widths
`define DATA_WIDTH      32
`define PHY_ADDR_WIDTH  24
`define ADDR_IMM_WIDTH  12
`define AL_PTR_WIDTH    5

// Emulated cache flush duration in cycles
`define FLUSH_CYCLES    4

// Implemented machine-mode CSR numbers
`define CSR_MSCRATCH    12'h340
`define CSR_MEPC        12'h341
`define CSR_MTVEC       12'h305

// Region codes in address bits [31:28]
`define REGION_IO       4'h4
`define REGION_MEM      4'h0

`endif

// File: src/memExPkg.sv
// ##################################################
// Types of the memory execution stage
// Widths come from the shared defines header
// ##################################################
`include "memExDefines.svh"

package memExPkg;

    typedef logic [`DATA_WIDTH-1:0]     DataPath;
    typedef logic [`DATA_WIDTH-1:0]     AddrPath;
    typedef logic [`PHY_ADDR_WIDTH-1:0] PhyAddrPath;
    typedef logic [`AL_PTR_WIDTH-1:0]   ActiveListPtrPath;

    // Memory immediate, also the CSR number of a CSR op
    typedef logic [`ADDR_IMM_WIDTH-1:0] AddrImmPath;

    // Register value with its ready bit
    typedef struct packed {
        logic    valid;
        DataPath data;
    } OperandData;

    typedef enum logic [1:0] {
        MEM_LOAD  = 2'd0,
        MEM_STORE = 2'd1,
        MEM_FENCE = 2'd2,
        MEM_CSR   = 2'd3
    } MemOpType;

    // Code 3 is unused
    typedef enum logic [1:0] {
        CSR_RW = 2'd0,
        CSR_RS = 2'd1,
        CSR_RC = 2'd2
    } CsrCode;

    typedef enum logic [1:0] {
        MMT_MEMORY  = 2'd0,
        MMT_IO      = 2'd1,
        MMT_ILLEGAL = 2'd2
    } MemoryMapType;

endpackage

// File: src/flushRangeDetector.sv
// ##################################################
// Selective flush test on an active-list pointer
// Range is [head, tail) with wraparound; head == tail is empty
// ##################################################
`timescale 1ns/1ps

module flushRangeDetector (
    input  logic                       toRecoveryPhase,
    input  memExPkg::ActiveListPtrPath flushRangeHead,
    input  memExPkg::ActiveListPtrPath flushRangeTail,
    input  logic                       flushAllInsns,
    input  memExPkg::ActiveListPtrPath activeListPtr,
    output logic                       flush
);
    import memExPkg::*;

    logic inRange;

    always_comb begin
        if (flushRangeHead <= flushRangeTail) begin
            inRange = (activeListPtr >= flushRangeHead) && (activeListPtr < flushRangeTail);
        end else begin
            // Range wraps past the end of the active list
            inRange = (activeListPtr >= flushRangeHead) || (activeListPtr < flushRangeTail);
        end
        flush = toRecoveryPhase && (flushAllInsns || inRange);
    end

endmodule

// File: src/addressUnit.sv
// ##################################################
// Effective address and memory-map classification
// Only the MEM region is cacheable
// ##################################################
`timescale 1ns/1ps
`include "memExDefines.svh"

module addressUnit (
    input  memExPkg::DataPath      base,
    input  memExPkg::AddrImmPath   addrIn,
    output memExPkg::AddrPath      addrOut,
    output memExPkg::PhyAddrPath   phyAddrOut,
    output memExPkg::MemoryMapType memMapType,
    output logic                   isUncachable
);
    import memExPkg::*;

    logic [3:0] region;

    always_comb begin
        addrOut = base + {{(`DATA_WIDTH-`ADDR_IMM_WIDTH){addrIn[`ADDR_IMM_WIDTH-1]}}, addrIn};
        region  = addrOut[`DATA_WIDTH-1 -: 4];

        case (region)
            `REGION_MEM: memMapType = MMT_MEMORY;
            `REGION_IO:  memMapType = MMT_IO;
            default:     memMapType = MMT_ILLEGAL;
        endcase

        // Physical space is the low address bits
        phyAddrOut   = addrOut[`PHY_ADDR_WIDTH-1:0];
        isUncachable = (memMapType != MMT_MEMORY);
    end

endmodule

// File: src/csrFile.sv
// ##################################################
// Machine-mode CSRs mscratch, mepc and mtvec
// Read value is the old value; other numbers read zero
// ##################################################
`timescale 1ns/1ps
`include "memExDefines.svh"

module csrFile (
    input  logic                 clk,
    input  logic                 arstN,
    input  logic                 csrWE,
    input  memExPkg::AddrImmPath csrNumber,
    input  memExPkg::DataPath    csrWriteIn,
    input  memExPkg::CsrCode     csrCode,
    output memExPkg::DataPath    csrReadOut
);
    import memExPkg::*;

    DataPath mscratch;
    DataPath mepc;
    DataPath mtvec;
    DataPath newValue;

    always_comb begin
        case (csrNumber)
            `CSR_MSCRATCH: csrReadOut = mscratch;
            `CSR_MEPC:     csrReadOut = mepc;
            `CSR_MTVEC:    csrReadOut = mtvec;
            default:       csrReadOut = '0;
        endcase

        // Read-modify-write on the old value
        case (csrCode)
            CSR_RW:  newValue = csrWriteIn;
            CSR_RS:  newValue = csrReadOut | csrWriteIn;
            CSR_RC:  newValue = csrReadOut & ~csrWriteIn;
            default: newValue = csrReadOut;
        endcase
    end

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            mscratch <= '0;
            mepc     <= '0;
            mtvec    <= '0;
        end else if (csrWE) begin
            case (csrNumber)
                `CSR_MSCRATCH: mscratch <= newValue;
                `CSR_MEPC:     mepc     <= newValue;
                `CSR_MTVEC:    mtvec    <= newValue;
                default:       ;
            endcase
        end
    end

endmodule

// File: src/cacheFlushSequencer.sv
// ##################################################
// Stand-in for the cache flush manager
// Completion pulses in the FLUSH_CYCLES-th cycle of the request
// Dropping the request restarts the count
// ##################################################
`timescale 1ns/1ps
`include "memExDefines.svh"

module cacheFlushSequencer (
    input  logic clk,
    input  logic arstN,
    input  logic cacheFlushReq,
    output logic cacheFlushComplete
);
    localparam int CntWidth = $clog2(`FLUSH_CYCLES);

    // Cycles of the current request already seen, zero when idle
    logic [CntWidth-1:0] flushCount;

    assign cacheFlushComplete =
        cacheFlushReq && (flushCount == CntWidth'(`FLUSH_CYCLES - 1));

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            flushCount <= '0;
        end else if (!cacheFlushReq || cacheFlushComplete) begin
            // Back to idle
            flushCount <= '0;
        end else begin
            flushCount <= flushCount + 1'b1;
        end
    end

endmodule

// File: src/memExecStage.sv
// ##################################################
// Memory execution stage, one issue lane
// Outputs are combinational from the pipeline register
// Stall holds the register; clear and flush kill the op in flight
// ##################################################
`timescale 1ns/1ps
`include "memExDefines.svh"

module memExecStage (
    input  logic                       clk,
    input  logic                       arstN,
    input  logic                       stall,
    input  logic                       clear,
    input  logic                       inValid,
    input  memExPkg::MemOpType         inOpType,
    input  memExPkg::AddrImmPath       inAddrIn,
    input  memExPkg::OperandData       inOperandA,
    input  memExPkg::OperandData       inOperandB,
    input  logic                       inIsFenceI,
    input  memExPkg::CsrCode           inCsrCode,
    input  logic                       inCsrIsImm,
    input  memExPkg::AddrImmPath       inCsrImm,
    input  memExPkg::ActiveListPtrPath inActiveListPtr,
    input  logic                       bypassSelA,
    input  logic                       bypassSelB,
    input  memExPkg::OperandData       bypassDataA,
    input  memExPkg::OperandData       bypassDataB,
    input  logic                       toRecoveryPhase,
    input  memExPkg::ActiveListPtrPath flushRangeHead,
    input  memExPkg::ActiveListPtrPath flushRangeTail,
    input  logic                       flushAllInsns,
    input  logic                       cacheFlushComplete,
    input  memExPkg::DataPath          csrReadOut,
    output logic                       dcReadReq,
    output memExPkg::PhyAddrPath       dcReadAddr,
    output logic                       dcReadUncachable,
    output memExPkg::ActiveListPtrPath dcReadActiveListPtr,
    output logic                       cacheFlushReq,
    output logic                       csrWE,
    output memExPkg::AddrImmPath       csrNumber,
    output memExPkg::DataPath          csrWriteIn,
    output memExPkg::CsrCode           csrCode,
    output logic                       outValid,
    output logic                       outRegValid,
    output memExPkg::DataPath          outDataIn,
    output memExPkg::AddrPath          outAddr,
    output memExPkg::PhyAddrPath       outPhyAddr,
    output memExPkg::MemoryMapType     outMemMapType,
    output memExPkg::MemOpType         outOpType,
    output memExPkg::ActiveListPtrPath outActiveListPtr
);
    import memExPkg::*;

    // Pipeline register
    logic             pipeValid;
    MemOpType         pipeOpType;
    AddrImmPath       pipeAddrIn;
    OperandData       pipeOperandA;
    OperandData       pipeOperandB;
    logic             pipeIsFenceI;
    CsrCode           pipeCsrCode;
    logic             pipeCsrIsImm;
    AddrImmPath       pipeCsrImm;
    ActiveListPtrPath pipeActiveListPtr;
    logic             pipeBypassSelA;
    logic             pipeBypassSelB;

    OperandData fuOpA;
    OperandData fuOpB;
    logic       flush;
    logic       isCsr;
    logic       isFenceI;
    logic       regValid;
    logic       canExecute;
    logic       isUncachable;
    PhyAddrPath phyAddr;

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            pipeValid <= 1'b0;
        end else if (!stall) begin
            pipeValid <= inValid;
        end
    end

    always_ff @(posedge clk) begin
        if (!stall) begin
            pipeOpType        <= inOpType;
            pipeAddrIn        <= inAddrIn;
            pipeOperandA      <= inOperandA;
            pipeOperandB      <= inOperandB;
            pipeIsFenceI      <= inIsFenceI;
            pipeCsrCode       <= inCsrCode;
            pipeCsrIsImm      <= inCsrIsImm;
            pipeCsrImm        <= inCsrImm;
            pipeActiveListPtr <= inActiveListPtr;
            pipeBypassSelA    <= bypassSelA;
            pipeBypassSelB    <= bypassSelB;
        end
    end

    flushRangeDetector flushRangeDetector_inst (
        .toRecoveryPhase (toRecoveryPhase),
        .flushRangeHead  (flushRangeHead),
        .flushRangeTail  (flushRangeTail),
        .flushAllInsns   (flushAllInsns),
        .activeListPtr   (pipeActiveListPtr),
        .flush           (flush)
    );

    addressUnit addressUnit_inst (
        .base         (fuOpA.data),
        .addrIn       (pipeAddrIn),
        .addrOut      (outAddr),
        .phyAddrOut   (phyAddr),
        .memMapType   (outMemMapType),
        .isUncachable (isUncachable)
    );

    always_comb begin
        // Bypass values are taken in this cycle
        fuOpA    = pipeBypassSelA ? bypassDataA : pipeOperandA;
        fuOpB    = pipeBypassSelB ? bypassDataB : pipeOperandB;
        isCsr    = (pipeOpType == MEM_CSR);
        isFenceI = pipeValid && (pipeOpType == MEM_FENCE) && pipeIsFenceI;

        case (pipeOpType)
            MEM_LOAD, MEM_STORE: regValid = fuOpA.valid && fuOpB.valid;
            MEM_CSR:             regValid = pipeCsrIsImm || fuOpA.valid;
            default:             regValid = 1'b1;
        endcase

        // FENCE.I replays until the cache flush is done
        cacheFlushReq = isFenceI;
        if (isFenceI && !cacheFlushComplete) begin
            regValid = 1'b0;
        end

        canExecute = pipeValid && regValid && !flush && !stall && !clear;

        dcReadReq           = canExecute && (pipeOpType == MEM_LOAD);
        dcReadAddr          = phyAddr;
        dcReadUncachable    = isUncachable;
        dcReadActiveListPtr = pipeActiveListPtr;

        csrWE      = canExecute && isCsr;
        csrNumber  = pipeAddrIn;
        csrCode    = pipeCsrCode;
        csrWriteIn = pipeCsrIsImm ?
            {{(`DATA_WIDTH-`ADDR_IMM_WIDTH){1'b0}}, pipeCsrImm} : fuOpA.data;

        outValid         = (stall || clear || flush) ? 1'b0 : pipeValid;
        outRegValid      = regValid;
        outDataIn        = isCsr ? csrReadOut : fuOpB.data;
        outPhyAddr       = phyAddr;
        outOpType        = pipeOpType;
        outActiveListPtr = pipeActiveListPtr;
    end

endmodule

// File: src/memExecTop.sv
// ##################################################
// Memory execution top with flush sequencer and CSR file
// Single issue lane; caches are modelled by the request side only
// ##################################################
`timescale 1ns/1ps

module memExecTop (
    input  logic                       clk,
    input  logic                       arstN,
    input  logic                       stall,
    input  logic                       clear,
    input  logic                       inValid,
    input  memExPkg::MemOpType         inOpType,
    input  memExPkg::AddrImmPath       inAddrIn,
    input  memExPkg::OperandData       inOperandA,
    input  memExPkg::OperandData       inOperandB,
    input  logic                       inIsFenceI,
    input  memExPkg::CsrCode           inCsrCode,
    input  logic                       inCsrIsImm,
    input  memExPkg::AddrImmPath       inCsrImm,
    input  memExPkg::ActiveListPtrPath inActiveListPtr,
    input  logic                       bypassSelA,
    input  logic                       bypassSelB,
    input  memExPkg::OperandData       bypassDataA,
    input  memExPkg::OperandData       bypassDataB,
    input  logic                       toRecoveryPhase,
    input  memExPkg::ActiveListPtrPath flushRangeHead,
    input  memExPkg::ActiveListPtrPath flushRangeTail,
    input  logic                       flushAllInsns,
    output logic                       dcReadReq,
    output memExPkg::PhyAddrPath       dcReadAddr,
    output logic                       dcReadUncachable,
    output memExPkg::ActiveListPtrPath dcReadActiveListPtr,
    output logic                       outValid,
    output logic                       outRegValid,
    output memExPkg::DataPath          outDataIn,
    output memExPkg::AddrPath          outAddr,
    output memExPkg::PhyAddrPath       outPhyAddr,
    output memExPkg::MemoryMapType     outMemMapType,
    output memExPkg::MemOpType         outOpType,
    output memExPkg::ActiveListPtrPath outActiveListPtr
);
    import memExPkg::*;

    // Flush handshake
    logic       cacheFlushReq;
    logic       cacheFlushComplete;

    // CSR access
    logic       csrWE;
    AddrImmPath csrNumber;
    DataPath    csrWriteIn;
    CsrCode     csrCode;
    DataPath    csrReadOut;

    // Port names match across the hierarchy
    memExecStage memExecStage_inst (.*);

    cacheFlushSequencer cacheFlushSequencer_inst (.*);

    csrFile csrFile_inst (.*);

endmodule

// File: dv/memExecTb.sv
// ##################################################
// Testbench for memExecTop with fixed-seed random ops
// Model covers the pipeline register, CSRs and flush count
// Outputs are sampled at the falling edge
// ##################################################
`timescale 1ns/1ps
`include "memExDefines.svh"

module memExecTb;
    import memExPkg::*;

    localparam int NumOps        = 600;
    localparam int TimeoutCycles = 8 + NumOps * 2 + 200;

    // Fields registered with the op
    typedef struct packed {
        logic             valid;
        MemOpType         opType;
        AddrImmPath       addrIn;
        OperandData       operandA;
        OperandData       operandB;
        logic             isFenceI;
        CsrCode           csrCode;
        logic             csrIsImm;
        AddrImmPath       csrImm;
        ActiveListPtrPath activeListPtr;
        logic             bypassSelA;
        logic             bypassSelB;
    } IssuedOp;

    logic             clk;
    logic             arstN;
    logic             stall;
    logic             clear;
    IssuedOp          issue;
    OperandData       bypassDataA;
    OperandData       bypassDataB;
    logic             toRecoveryPhase;
    ActiveListPtrPath flushRangeHead;
    ActiveListPtrPath flushRangeTail;
    logic             flushAllInsns;
    logic             dcReadReq;
    PhyAddrPath       dcReadAddr;
    logic             dcReadUncachable;
    ActiveListPtrPath dcReadActiveListPtr;
    logic             outValid;
    logic             outRegValid;
    DataPath          outDataIn;
    AddrPath          outAddr;
    PhyAddrPath       outPhyAddr;
    MemoryMapType     outMemMapType;
    MemOpType         outOpType;
    ActiveListPtrPath outActiveListPtr;

    memExecTop memExecTop_inst (
        .inValid         (issue.valid),
        .inOpType        (issue.opType),
        .inAddrIn        (issue.addrIn),
        .inOperandA      (issue.operandA),
        .inOperandB      (issue.operandB),
        .inIsFenceI      (issue.isFenceI),
        .inCsrCode       (issue.csrCode),
        .inCsrIsImm      (issue.csrIsImm),
        .inCsrImm        (issue.csrImm),
        .inActiveListPtr (issue.activeListPtr),
        .bypassSelA      (issue.bypassSelA),
        .bypassSelB      (issue.bypassSelB),
        .*
    );

    integer      seed           = 32'h43a86eb1;
    int          errorCount     = 0;
    int          checkCount     = 0;
    int          cycleCount     = 0;
    int          fenceDoneCount = 0;
    int          flushSeen      = 0;
    int unsigned recoveryLeft   = 0;

    // Reference state
    IssuedOp    pipeModel;
    DataPath    mscratch;
    DataPath    mepc;
    DataPath    mtvec;

    // Effects that land at the next rising edge
    logic       pendCsrWrite;
    AddrImmPath pendCsrNum;
    DataPath    pendCsrValue;
    logic       pendFlushReq;
    logic       pendFlushDone;

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    initial begin
        while (cycleCount < TimeoutCycles) begin
            @(posedge clk);
            cycleCount++;
        end
        $display("Timeout: the run did not finish within %0d cycles", TimeoutCycles);
        $display("RESULT: FAIL");
        $finish;
    end

    function automatic logic [31:0] randWord();
        return $random(seed);
    endfunction

    function automatic int unsigned randBelow(int unsigned n);
        return randWord() % n;
    endfunction

    // Mostly in the MEM or IO region
    function automatic DataPath randBase();
        DataPath     r;
        int unsigned pick;
        r    = randWord();
        pick = randBelow(3);
        if (pick == 0) begin
            r[31:28] = `REGION_MEM;
        end else if (pick == 1) begin
            r[31:28] = `REGION_IO;
        end
        return r;
    endfunction

    function automatic DataPath csrRead(AddrImmPath num);
        case (num)
            `CSR_MSCRATCH: return mscratch;
            `CSR_MEPC:     return mepc;
            `CSR_MTVEC:    return mtvec;
            default:       return '0;
        endcase
    endfunction

    // Distance from head below the range length, so wraparound needs no special case
    function automatic logic inFlushRange(ActiveListPtrPath ptr);
        ActiveListPtrPath offset;
        ActiveListPtrPath span;
        offset = ptr - flushRangeHead;
        span   = flushRangeTail - flushRangeHead;
        return offset < span;
    endfunction

    task automatic compareValue(input string what, input logic [31:0] got,
                                input logic [31:0] exp);
        checkCount++;
        assert (got === exp) else begin
            errorCount++;
            $display("[ERROR] %0d ns: %s is %h, expected %h", $time, what, got, exp);
        end
    endtask

    task automatic driveRandomOp();
        logic [31:0]      r;
        int unsigned      pick;
        ActiveListPtrPath span;
        r    = randWord();
        pick = randBelow(10);
        issue.valid = randBelow(10) < 8;
        if (pick < 4) begin
            issue.opType = MEM_LOAD;
        end else if (pick < 6) begin
            issue.opType = MEM_STORE;
        end else if (pick < 8) begin
            issue.opType = MEM_CSR;
        end else begin
            issue.opType = MEM_FENCE;
        end
        issue.isFenceI       = (issue.opType == MEM_FENCE) && (randBelow(2) == 0);
        issue.operandA.valid = randBelow(10) < 8;
        issue.operandA.data  = randBase();
        issue.operandB.valid = randBelow(10) < 8;
        issue.operandB.data  = randWord();
        issue.bypassSelA     = randBelow(4) == 0;
        issue.bypassSelB     = randBelow(4) == 0;
        bypassDataA.valid    = randBelow(10) < 8;
        bypassDataA.data     = randBase();
        bypassDataB.valid    = randBelow(10) < 8;
        bypassDataB.data     = randWord();

        // CSR ops mostly target implemented numbers
        issue.addrIn = r[11:0];
        if (issue.opType == MEM_CSR) begin
            case (randBelow(4))
                0:       issue.addrIn = `CSR_MSCRATCH;
                1:       issue.addrIn = `CSR_MEPC;
                2:       issue.addrIn = `CSR_MTVEC;
                default: ;
            endcase
        end
        case (randBelow(3))
            0:       issue.csrCode = CSR_RW;
            1:       issue.csrCode = CSR_RS;
            default: issue.csrCode = CSR_RC;
        endcase
        issue.csrIsImm      = randBelow(2) == 0;
        issue.csrImm        = r[23:12];
        issue.activeListPtr = r[28:24];

        // Recovery window open for a few cycles
        if (recoveryLeft == 0 && randBelow(100) < 20) begin
            r              = randWord();
            recoveryLeft   = 2 + randBelow(4);
            flushRangeHead = r[4:0];
            flushRangeTail = r[9:5];
            flushAllInsns  = r[12:10] == 3'd0;
        end
        toRecoveryPhase = recoveryLeft != 0;
        if (recoveryLeft != 0) begin
            recoveryLeft--;
        end

        // Half the loads aim inside a window still open next cycle
        span = flushRangeTail - flushRangeHead;
        if (issue.opType == MEM_LOAD && recoveryLeft != 0 && span != 0 &&
            randBelow(2) == 0) begin
            pick                = randBelow(32'(span));
            issue.activeListPtr = flushRangeHead + pick[4:0];
        end
        stall = randBelow(100) < 15;
        clear = randBelow(100) < 5;
    endtask

    task automatic nextEdge();
        @(posedge clk);
        if (pendCsrWrite) begin
            case (pendCsrNum)
                `CSR_MSCRATCH: mscratch = pendCsrValue;
                `CSR_MEPC:     mepc     = pendCsrValue;
                `CSR_MTVEC:    mtvec    = pendCsrValue;
                default:       ;
            endcase
        end
        // Sequencer goes idle on completion or a dropped request
        if (!pendFlushReq || pendFlushDone) begin
            flushSeen = 0;
        end else begin
            flushSeen++;
        end
        if (!stall) begin
            pipeModel = issue;
        end
        #1;
    endtask

    task automatic checkOutputs();
        OperandData   a;
        OperandData   b;
        logic         flushHit;
        logic         fenceI;
        logic         flushDone;
        logic         ready;
        logic         execOk;
        DataPath      addr;
        MemoryMapType mmt;
        DataPath      oldCsr;
        DataPath      writeVal;
        @(negedge clk);
        a         = pipeModel.bypassSelA ? bypassDataA : pipeModel.operandA;
        b         = pipeModel.bypassSelB ? bypassDataB : pipeModel.operandB;
        flushHit  = toRecoveryPhase && (flushAllInsns || inFlushRange(pipeModel.activeListPtr));
        fenceI    = pipeModel.valid && pipeModel.opType == MEM_FENCE && pipeModel.isFenceI;
        flushDone = fenceI && flushSeen == `FLUSH_CYCLES - 1;
        case (pipeModel.opType)
            MEM_LOAD, MEM_STORE: ready = a.valid && b.valid;
            MEM_CSR:             ready = pipeModel.csrIsImm || a.valid;
            default:             ready = !fenceI || flushDone;
        endcase
        execOk = pipeModel.valid && ready && !flushHit && !stall && !clear;

        // Immediate is a signed offset
        addr = a.data + 32'(signed'(pipeModel.addrIn));
        if (addr[31:28] == `REGION_MEM) begin
            mmt = MMT_MEMORY;
        end else if (addr[31:28] == `REGION_IO) begin
            mmt = MMT_IO;
        end else begin
            mmt = MMT_ILLEGAL;
        end

        oldCsr   = csrRead(pipeModel.addrIn);
        writeVal = pipeModel.csrIsImm ? DataPath'(pipeModel.csrImm) : a.data;
        case (pipeModel.csrCode)
            CSR_RW:  pendCsrValue = writeVal;
            CSR_RS:  pendCsrValue = oldCsr | writeVal;
            default: pendCsrValue = oldCsr & ~writeVal;
        endcase
        pendCsrWrite  = execOk && pipeModel.opType == MEM_CSR;
        pendCsrNum    = pipeModel.addrIn;
        pendFlushReq  = fenceI;
        pendFlushDone = flushDone;

        // FENCE.I released by the DUT
        if (fenceI && outRegValid === 1'b1) begin
            fenceDoneCount++;
        end

        compareValue("outValid", 32'(outValid),
                     32'(pipeModel.valid && !(stall || clear || flushHit)));
        compareValue("dcReadReq", 32'(dcReadReq), 32'(execOk && pipeModel.opType == MEM_LOAD));
        if (pipeModel.valid) begin
            compareValue("outRegValid", 32'(outRegValid), 32'(ready));
            compareValue("outDataIn", outDataIn,
                         pipeModel.opType == MEM_CSR ? oldCsr : b.data);
            compareValue("outAddr", outAddr, addr);
            compareValue("outPhyAddr", 32'(outPhyAddr), 32'(addr[`PHY_ADDR_WIDTH-1:0]));
            compareValue("outMemMapType", 32'(outMemMapType), 32'(mmt));
            compareValue("dcReadAddr", 32'(dcReadAddr), 32'(addr[`PHY_ADDR_WIDTH-1:0]));
            compareValue("dcReadUncachable", 32'(dcReadUncachable), 32'(mmt != MMT_MEMORY));
            compareValue("dcReadActiveListPtr", 32'(dcReadActiveListPtr),
                         32'(pipeModel.activeListPtr));
            compareValue("outOpType", 32'(outOpType), 32'(pipeModel.opType));
            compareValue("outActiveListPtr", 32'(outActiveListPtr),
                         32'(pipeModel.activeListPtr));
        end
    endtask

    initial begin
        arstN           = 1'b0;
        stall           = 1'b0;
        clear           = 1'b0;
        issue           = '0;
        bypassDataA     = '0;
        bypassDataB     = '0;
        toRecoveryPhase = 1'b0;
        flushRangeHead  = '0;
        flushRangeTail  = '0;
        flushAllInsns   = 1'b0;
        pipeModel       = '0;
        mscratch        = '0;
        mepc            = '0;
        mtvec           = '0;
        pendCsrWrite    = 1'b0;
        pendFlushReq    = 1'b0;
        pendFlushDone   = 1'b0;

        repeat (8) @(posedge clk);
        #1;
        arstN = 1'b1;
        // Empty pipeline right after reset
        checkOutputs();

        for (int i = 0; i < NumOps; i++) begin
            nextEdge();
            driveRandomOp();
            checkOutputs();
        end

        // FENCE.I held by stall across a full flush
        nextEdge();
        driveRandomOp();
        issue.valid    = 1'b1;
        issue.opType   = MEM_FENCE;
        issue.isFenceI = 1'b1;
        stall          = 1'b0;
        checkOutputs();
        repeat (`FLUSH_CYCLES + 2) begin
            nextEdge();
            driveRandomOp();
            stall = 1'b1;
            checkOutputs();
        end

        assert (fenceDoneCount > 0) else begin
            errorCount++;
            $display("No FENCE.I cache flush ever completed during the run");
        end

        $display("Finished: %0d checks, %0d errors", checkCount, errorCount);
        if (errorCount == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

// File: sim.f
+incdir+src
src/memExPkg.sv
src/flushRangeDetector.sv
src/addressUnit.sv
src/csrFile.sv
src/cacheFlushSequencer.sv
src/memExecStage.sv
src/memExecTop.sv
dv/memExecTb.sv

// File: run.sh
#!/bin/sh
# Builds and runs the memExecTop testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f sim.f --top-module memExecTb -o memExecSim

./obj_dir/memExecSim > sim.log
cat sim.log

# Pass only when the testbench printed the pass line
grep -q "^RESULT: PASS$" sim.log
